// File: common/fabric_bus_pkg.sv
// fabric bus definitions
// widths and packed request/response structs for the lint register bus
// and the TCDM master ports
`default_nettype none

package fabric_bus_pkg;

  localparam int DATA_W  = 32;
  localparam int BE_W    = 4;
  localparam int LINT_AW = 20;
  localparam int TCDM_AW = 20;

  typedef struct packed {
    logic               req;
    logic               wen;    // low for write
    logic [LINT_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [BE_W-1:0]    be;
  } lint_req_t;

  typedef struct packed {
    logic              gnt;
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } lint_rsp_t;

  typedef struct packed {
    logic               req;
    logic               wen;    // high for read, same as lint
    logic [TCDM_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [BE_W-1:0]    be;
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;
    logic              valid;   // one or more cycles after gnt
    logic [DATA_W-1:0] rdata;
  } tcdm_rsp_t;

endpackage

`default_nettype wire

// File: common/fabric_regmap_pkg.sv
// fabric test register map
// offsets, RAM window codes, port config struct and bus word field positions
`default_nettype none

package fabric_regmap_pkg;
  import fabric_bus_pkg::*;

  localparam int N_PORTS  = 2;
  localparam int RAM_AW   = 6;     // 64 words per operand RAM
  localparam int FPGAIO_W = 80;
  localparam int IO_WORDS = 3;     // bus words covering one I/O vector
  localparam int BLEN_W   = 8;
  localparam int EVENTS_W = 16;

  localparam logic [LINT_AW-1:0] PORT_CFG_BASE = 20'h00000;
  localparam logic [LINT_AW-1:0] PORT_STRIDE   = 20'h00004;
  localparam logic [LINT_AW-1:0] FPGAIO_OUT    = 20'h00040;
  localparam logic [LINT_AW-1:0] FPGAIO_OE     = 20'h00050;
  localparam logic [LINT_AW-1:0] FPGAIO_IN     = 20'h00060;
  localparam logic [LINT_AW-1:0] BURST_LEN     = 20'h00070;
  localparam logic [LINT_AW-1:0] BUSY_STATUS   = 20'h00074;
  localparam logic [LINT_AW-1:0] SINGLE_BASE   = 20'h00080;
  localparam logic [LINT_AW-1:0] LAUNCH_BASE   = 20'h00200;
  localparam logic [LINT_AW-1:0] ID_ADDR       = 20'h00800;

  localparam logic [DATA_W-1:0] ID_WORD     = 32'hca11ef3a;
  localparam logic [DATA_W-1:0] IO_TOP_MASK = 32'h0000ffff;  // bits 79:64 of the vector

  // top address byte selects a RAM window, port p at RAM_WIN_BASE + p
  localparam logic [7:0] RAM_WIN_BASE = 8'h01;
  localparam int         WIN_LSB      = 12;

  localparam int CFG_WEN_BIT  = 31;
  localparam int CFG_BE_LSB   = 20;  // inverted byte enables
  localparam int CFG_ADDR_LSB = 0;

  typedef struct packed {
    logic [TCDM_AW-1:0] addr;
    logic [BE_W-1:0]    be;
    logic               wen;
  } port_cfg_t;

endpackage

`default_nettype wire

// File: hdl/oper_ram.sv
// operand RAM
// 64 x 32 dual-port array, both ports read and write, one cycle read latency
`timescale 1ns/1ps
`default_nettype none

module oper_ram
  import fabric_bus_pkg::*, fabric_regmap_pkg::*;
(
  input  logic              CLK,
  input  logic [RAM_AW-1:0] a_addr,
  input  logic              a_we,
  input  logic [DATA_W-1:0] a_wdata,
  output logic [DATA_W-1:0] a_rdata,
  input  logic [RAM_AW-1:0] b_addr,
  input  logic              b_we,
  input  logic [DATA_W-1:0] b_wdata,
  output logic [DATA_W-1:0] b_rdata
);

  logic [DATA_W-1:0] mem [2**RAM_AW];

  always_ff @(posedge CLK) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;   // bus side
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;   // engine side
    end
    a_rdata <= mem[a_addr];     // read returns old contents
    b_rdata <= mem[b_addr];
  end

endmodule

`default_nettype wire

// File: lint_slave/lint_reg_slave.sv
// lint register slave
// request/grant handshake FSM, register decode and read mux,
// I/O and burst length registers, engine control pulses and RAM windows
`timescale 1ns/1ps
`default_nettype none

module lint_reg_slave
  import fabric_bus_pkg::*, fabric_regmap_pkg::*;
(
  input  logic                CLK,
  input  logic                rst,
  input  lint_req_t           lint_req,
  output lint_rsp_t           lint_rsp,
  output logic [N_PORTS-1:0]  cfg_we,
  output port_cfg_t           cfg_wr,
  output logic [N_PORTS-1:0]  launch,
  output logic [N_PORTS-1:0]  single,
  output logic [DATA_W-1:0]   single_wdata,
  output logic [BLEN_W-1:0]   burst_len,
  input  logic [N_PORTS-1:0]  eng_busy,
  input  port_cfg_t           eng_cfg [N_PORTS],
  input  logic [DATA_W-1:0]   eng_result [N_PORTS],
  output logic [RAM_AW-1:0]   ram_a_addr [N_PORTS],
  output logic [N_PORTS-1:0]  ram_a_we,
  output logic [DATA_W-1:0]   ram_a_wdata [N_PORTS],
  input  logic [DATA_W-1:0]   ram_a_rdata [N_PORTS],
  input  logic [FPGAIO_W-1:0] fpgaio_in,
  output logic [FPGAIO_W-1:0] fpgaio_out,
  output logic [FPGAIO_W-1:0] fpgaio_oe,
  output logic [EVENTS_W-1:0] events
);

  typedef enum logic [1:0] {st_idle, st_write, st_read, st_read_wait} state_t;

  state_t                     state;
  logic                       gnt_q;
  logic                       valid_q;
  logic [DATA_W-1:0]          rdata_q;
  logic [IO_WORDS*DATA_W-1:0] io_out_q;
  logic [IO_WORDS*DATA_W-1:0] io_oe_q;
  logic [IO_WORDS*DATA_W-1:0] io_in_w;
  logic [1:0]                 io_idx;
  logic                       io_sel;
  logic                       io_out_hit;
  logic                       io_oe_hit;
  logic                       io_in_hit;
  logic                       blen_hit;
  logic                       busy_hit;
  logic                       id_hit;
  logic [N_PORTS-1:0]         cfg_hit;
  logic [N_PORTS-1:0]         single_hit;
  logic [N_PORTS-1:0]         launch_hit;
  logic [N_PORTS-1:0]         win_hit;
  logic                       accept;
  logic                       wr_accept;
  logic [DATA_W-1:0]          io_cur;
  logic [DATA_W-1:0]          io_new;
  logic                       rd_hit;
  logic [DATA_W-1:0]          rd_word;

  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_w,
                                                 input logic [DATA_W-1:0] new_w,
                                                 input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    for (int i = 0; i < BE_W; i++) begin
      res[8*i +: 8] = be[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] cfg_to_word(input port_cfg_t c);
    logic [DATA_W-1:0] w;
    w = '0;
    w[CFG_WEN_BIT] = c.wen;
    w[CFG_BE_LSB +: BE_W] = ~c.be;
    w[CFG_ADDR_LSB +: TCDM_AW] = c.addr;
    return w;
  endfunction

  // master holds the request until gnt, so decode runs on the live address
  always_comb begin
    io_idx     = lint_req.addr[3:2];
    io_sel     = (lint_req.addr[1:0] == 2'b00) && (32'(io_idx) < IO_WORDS);
    io_out_hit = io_sel && (lint_req.addr[LINT_AW-1:4] == FPGAIO_OUT[LINT_AW-1:4]);
    io_oe_hit  = io_sel && (lint_req.addr[LINT_AW-1:4] == FPGAIO_OE[LINT_AW-1:4]);
    io_in_hit  = io_sel && (lint_req.addr[LINT_AW-1:4] == FPGAIO_IN[LINT_AW-1:4]);
    blen_hit   = (lint_req.addr == BURST_LEN);
    busy_hit   = (lint_req.addr == BUSY_STATUS);
    id_hit     = (lint_req.addr == ID_ADDR);
    for (int p = 0; p < N_PORTS; p++) begin
      cfg_hit[p]    = (lint_req.addr == PORT_CFG_BASE + LINT_AW'(p) * PORT_STRIDE);
      single_hit[p] = (lint_req.addr == SINGLE_BASE + LINT_AW'(p) * PORT_STRIDE);
      launch_hit[p] = (lint_req.addr == LAUNCH_BASE + LINT_AW'(p) * PORT_STRIDE);
      win_hit[p]    = (lint_req.addr[LINT_AW-1:WIN_LSB] == RAM_WIN_BASE + 8'(p));
    end
  end

  assign accept    = (state == st_idle) && lint_req.req && !gnt_q;
  assign wr_accept = accept && !lint_req.wen;

  // byte-merged I/O word, top word only carries bits 79:64
  always_comb begin
    io_cur = io_oe_hit ? io_oe_q[io_idx*DATA_W +: DATA_W] : io_out_q[io_idx*DATA_W +: DATA_W];
    io_new = be_merge(io_cur, lint_req.wdata, lint_req.be);
    if (32'(io_idx) == IO_WORDS - 1) begin
      io_new = io_new & IO_TOP_MASK;
    end
  end

  // RAM port A follows the bus address, written at acceptance
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      ram_a_addr[p]  = lint_req.addr[RAM_AW+1:2];
      ram_a_wdata[p] = lint_req.wdata;
      ram_a_we[p]    = wr_accept && win_hit[p];
    end
  end

  assign io_in_w = (IO_WORDS*DATA_W)'(fpgaio_in);

  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    if (id_hit)          rd_word = ID_WORD;
    else if (blen_hit)   rd_word = DATA_W'(burst_len);
    else if (busy_hit)   rd_word = DATA_W'(eng_busy);
    else if (io_out_hit) rd_word = io_out_q[io_idx*DATA_W +: DATA_W];
    else if (io_oe_hit)  rd_word = io_oe_q[io_idx*DATA_W +: DATA_W];
    else if (io_in_hit)  rd_word = io_in_w[io_idx*DATA_W +: DATA_W];
    else begin
      rd_hit = |(cfg_hit | single_hit | win_hit);   // launch offsets read as unmapped
      for (int p = 0; p < N_PORTS; p++) begin
        if (cfg_hit[p])    rd_word = cfg_to_word(eng_cfg[p]);
        if (single_hit[p]) rd_word = eng_result[p];
        if (win_hit[p])    rd_word = ram_a_rdata[p];  // addressed since acceptance
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= st_idle;
      gnt_q     <= 1'b0;
      valid_q   <= 1'b0;
      cfg_we    <= '0;
      launch    <= '0;
      single    <= '0;
      burst_len <= '0;
      io_out_q  <= '0;
      io_oe_q   <= '0;
    end else begin
      cfg_we <= '0;   // single-cycle pulses
      launch <= '0;
      single <= '0;
      case (state)
        st_idle: begin
          valid_q <= 1'b0;
          if (wr_accept) begin
            gnt_q  <= 1'b1;
            state  <= st_write;
            cfg_we <= cfg_hit;
            launch <= launch_hit;
            single <= single_hit;
            if (blen_hit) burst_len <= lint_req.wdata[BLEN_W-1:0];
            if (io_out_hit) io_out_q[io_idx*DATA_W +: DATA_W] <= io_new;
            if (io_oe_hit) io_oe_q[io_idx*DATA_W +: DATA_W] <= io_new;
          end else if (accept) begin
            state <= st_read;
          end
        end
        st_write: begin
          gnt_q   <= 1'b0;
          valid_q <= 1'b1;
          state   <= st_idle;
        end
        st_read: begin
          gnt_q <= 1'b1;   // rdata_q settles on the same edge
          state <= st_read_wait;
        end
        default: begin
          gnt_q   <= 1'b0;
          valid_q <= 1'b1;
          state   <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == st_read && rd_hit) begin
      rdata_q <= rd_word;   // unmapped keeps the old word
    end
    if (wr_accept && |cfg_hit) begin
      cfg_wr.addr <= lint_req.wdata[CFG_ADDR_LSB +: TCDM_AW];
      cfg_wr.be   <= ~lint_req.wdata[CFG_BE_LSB +: BE_W];
      cfg_wr.wen  <= lint_req.wdata[CFG_WEN_BIT];
    end
    if (wr_accept && |single_hit) begin
      single_wdata <= lint_req.wdata;
    end
  end

  assign lint_rsp   = '{gnt: gnt_q, valid: valid_q, rdata: rdata_q};
  assign fpgaio_out = io_out_q[FPGAIO_W-1:0];
  assign fpgaio_oe  = io_oe_q[FPGAIO_W-1:0];
  assign events     = fpgaio_in[EVENTS_W-1:0];

endmodule

`default_nettype wire

// File: tcdm_dma/tcdm_burst_engine.sv
// TCDM burst engine
// read bursts fill the operand RAM from TCDM, write bursts send RAM words out,
// single accesses issue one request with the bus data
`timescale 1ns/1ps
`default_nettype none

module tcdm_burst_engine
  import fabric_bus_pkg::*, fabric_regmap_pkg::*;
(
  input  logic              CLK,
  input  logic              rst,
  input  logic              cfg_we,
  input  port_cfg_t         cfg_wr,
  input  logic              launch,
  input  logic              single,
  input  logic [DATA_W-1:0] single_wdata,
  input  logic [BLEN_W-1:0] burst_len,
  output tcdm_req_t         tcdm_req,
  input  tcdm_rsp_t         tcdm_rsp,
  output logic [RAM_AW-1:0] ram_b_addr,
  output logic              ram_b_we,
  output logic [DATA_W-1:0] ram_b_wdata,
  input  logic [DATA_W-1:0] ram_b_rdata,
  output logic              busy,
  output port_cfg_t         cfg,
  output logic [DATA_W-1:0] result
);

  typedef enum logic [1:0] {st_idle, st_prefetch, st_req, st_wait} state_t;

  state_t            state;
  port_cfg_t         cfg_q;
  logic [BLEN_W-1:0] cnt;         // words done in this burst
  logic [BLEN_W-1:0] len_q;
  logic              burst_q;
  logic              req_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] result_q;
  logic              last_word;

  assign last_word = (BLEN_W'(cnt + 1'b1) == len_q);

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= st_idle;
      cfg_q   <= '0;
      cnt     <= '0;
      burst_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          cnt <= '0;
          if (cfg_we) cfg_q <= cfg_wr;   // config only changes between accesses
          if (launch && burst_len != '0) begin
            burst_q <= 1'b1;
            if (cfg_q.wen) begin
              req_q <= 1'b1;
              state <= st_req;
            end else begin
              state <= st_prefetch;   // RAM word 0 first
            end
          end else if (single) begin
            burst_q <= 1'b0;
            req_q   <= 1'b1;
            state   <= st_req;
          end
        end
        st_prefetch: begin
          req_q <= 1'b1;
          state <= st_req;
        end
        st_req: begin
          if (tcdm_rsp.gnt) begin
            req_q <= 1'b0;
            state <= st_wait;
            if (burst_q) cfg_q.addr <= cfg_q.addr + TCDM_AW'(4);
          end
        end
        default: begin
          if (tcdm_rsp.valid) begin
            cnt <= cnt + 1'b1;
            if (!burst_q || last_word) begin
              state <= st_idle;
            end else if (cfg_q.wen) begin
              req_q <= 1'b1;
              state <= st_req;
            end else begin
              state <= st_prefetch;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == st_idle) begin
      len_q <= burst_len;   // sampled at launch
      if (single) wdata_q <= single_wdata;
    end
    if (state == st_wait && tcdm_rsp.valid && cfg_q.wen) begin
      result_q <= tcdm_rsp.rdata;
    end
  end

  // RAM output holds while the address holds, so wdata is stable until gnt
  assign tcdm_req = '{req:   req_q,
                      wen:   cfg_q.wen,
                      addr:  cfg_q.addr,
                      wdata: burst_q ? ram_b_rdata : wdata_q,
                      be:    cfg_q.be};

  assign ram_b_addr  = cnt[RAM_AW-1:0];
  assign ram_b_we    = (state == st_wait) && tcdm_rsp.valid && burst_q && cfg_q.wen;
  assign ram_b_wdata = tcdm_rsp.rdata;

  assign busy   = (state != st_idle);
  assign cfg    = cfg_q;
  assign result = result_q;

endmodule

`default_nettype wire

// File: hdl/fabric_test_top.sv
// fabric test block top
// lint register slave, one TCDM burst engine and operand RAM per port
`timescale 1ns/1ps
`default_nettype none

module fabric_test_top
  import fabric_bus_pkg::*, fabric_regmap_pkg::*;
(
  input  logic                CLK,
  input  logic                rst,
  input  lint_req_t           lint_req,
  output lint_rsp_t           lint_rsp,
  output tcdm_req_t           tcdm_req [N_PORTS],
  input  tcdm_rsp_t           tcdm_rsp [N_PORTS],
  input  logic [FPGAIO_W-1:0] fpgaio_in,
  output logic [FPGAIO_W-1:0] fpgaio_out,
  output logic [FPGAIO_W-1:0] fpgaio_oe,
  output logic [EVENTS_W-1:0] events
);

  port_cfg_t          cfg_wr;
  logic [N_PORTS-1:0] cfg_we;
  logic [N_PORTS-1:0] launch;
  logic [N_PORTS-1:0] single;
  logic [DATA_W-1:0]  single_wdata;
  logic [BLEN_W-1:0]  burst_len;
  logic [N_PORTS-1:0] eng_busy;
  port_cfg_t          eng_cfg [N_PORTS];
  logic [DATA_W-1:0]  eng_result [N_PORTS];

  logic [RAM_AW-1:0]  ram_a_addr [N_PORTS];
  logic [N_PORTS-1:0] ram_a_we;
  logic [DATA_W-1:0]  ram_a_wdata [N_PORTS];
  logic [DATA_W-1:0]  ram_a_rdata [N_PORTS];
  logic [RAM_AW-1:0]  ram_b_addr [N_PORTS];
  logic [N_PORTS-1:0] ram_b_we;
  logic [DATA_W-1:0]  ram_b_wdata [N_PORTS];
  logic [DATA_W-1:0]  ram_b_rdata [N_PORTS];

  lint_reg_slave i_lint_slave (
    .CLK          (CLK),
    .rst          (rst),
    .lint_req     (lint_req),
    .lint_rsp     (lint_rsp),
    .cfg_we       (cfg_we),
    .cfg_wr       (cfg_wr),
    .launch       (launch),
    .single       (single),
    .single_wdata (single_wdata),
    .burst_len    (burst_len),
    .eng_busy     (eng_busy),
    .eng_cfg      (eng_cfg),
    .eng_result   (eng_result),
    .ram_a_addr   (ram_a_addr),
    .ram_a_we     (ram_a_we),
    .ram_a_wdata  (ram_a_wdata),
    .ram_a_rdata  (ram_a_rdata),
    .fpgaio_in    (fpgaio_in),
    .fpgaio_out   (fpgaio_out),
    .fpgaio_oe    (fpgaio_oe),
    .events       (events)
  );

  for (genvar g = 0; g < N_PORTS; g++) begin : g_port
    tcdm_burst_engine i_engine (
      .CLK          (CLK),
      .rst          (rst),
      .cfg_we       (cfg_we[g]),
      .cfg_wr       (cfg_wr),
      .launch       (launch[g]),
      .single       (single[g]),
      .single_wdata (single_wdata),
      .burst_len    (burst_len),      // shared by all engines
      .tcdm_req     (tcdm_req[g]),
      .tcdm_rsp     (tcdm_rsp[g]),
      .ram_b_addr   (ram_b_addr[g]),
      .ram_b_we     (ram_b_we[g]),
      .ram_b_wdata  (ram_b_wdata[g]),
      .ram_b_rdata  (ram_b_rdata[g]),
      .busy         (eng_busy[g]),
      .cfg          (eng_cfg[g]),
      .result       (eng_result[g])
    );

    oper_ram i_ram (
      .CLK     (CLK),
      .a_addr  (ram_a_addr[g]),
      .a_we    (ram_a_we[g]),
      .a_wdata (ram_a_wdata[g]),
      .a_rdata (ram_a_rdata[g]),
      .b_addr  (ram_b_addr[g]),
      .b_we    (ram_b_we[g]),
      .b_wdata (ram_b_wdata[g]),
      .b_rdata (ram_b_rdata[g])
    );
  end

endmodule

`default_nettype wire

// File: dv/tb_tcdm_mem.sv
// TCDM memory model
// 256-word array, grant after 0 to 3 idle cycles, valid one cycle after gnt
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_mem
  import fabric_bus_pkg::*;
#(
  parameter logic [31:0] SEED = 32'd40
) (
  input  wire logic      CLK,
  input  wire logic      rst,
  input  wire tcdm_req_t req,
  output tcdm_rsp_t      rsp
);

  logic [DATA_W-1:0] mem [256];
  logic [1:0]        phase;
  logic [1:0]        delay;
  logic [31:0]       lcg_q;
  logic              gnt_q;
  logic              valid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [7:0]        idx;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign idx = req.addr[9:2];   // word index

  always @(posedge CLK) begin
    if (rst) begin
      phase   <= 2'd0;
      delay   <= 2'd0;
      lcg_q   <= SEED;
      gnt_q   <= 1'b0;
      valid_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      case (phase)
        2'd0: begin
          if (req.req && delay == 2'd0) begin
            gnt_q <= 1'b1;
            phase <= 2'd1;
            if (req.wen) begin
              rdata_q <= mem[idx];
            end else begin
              for (int i = 0; i < BE_W; i++) begin
                if (req.be[i]) mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
              end
            end
          end else if (req.req) begin
            delay <= delay - 2'd1;   // idle cycle before gnt
          end
        end
        2'd1: begin
          gnt_q   <= 1'b0;
          valid_q <= 1'b1;
          phase   <= 2'd2;
        end
        default: begin
          valid_q <= 1'b0;
          lcg_q   <= lcg_next(lcg_q);
          delay   <= lcg_q[17:16];   // next grant delay
          phase   <= 2'd0;
        end
      endcase
    end
  end

  assign rsp = '{gnt: gnt_q, valid: valid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: dv/tcdm_burst_chk.sv
// TCDM handshake checker
// bound into every burst engine, watches request hold and reset state
`timescale 1ns/1ps
`default_nettype none

module tcdm_burst_chk
  import fabric_bus_pkg::*;
(
  input wire logic      CLK,
  input wire logic      rst,
  input wire tcdm_req_t req,
  input wire tcdm_rsp_t rsp,
  input wire logic      busy
);

  a_req_hold : assert property (@(posedge CLK) disable iff (rst)
    (req.req && !rsp.gnt) |=> req.req)
    else $error("tcdm req dropped before gnt");

  a_addr_hold : assert property (@(posedge CLK) disable iff (rst)
    (req.req && !rsp.gnt) |=> $stable(req.addr))
    else $error("tcdm addr changed while waiting for gnt");

  // read requests carry no data
  a_wdata_hold : assert property (@(posedge CLK) disable iff (rst)
    (req.req && !rsp.gnt && !req.wen) |=> $stable(req.wdata))
    else $error("tcdm wdata changed while waiting for gnt");

  a_busy_reset : assert property (@(posedge CLK) rst |=> !busy)
    else $error("engine busy in the cycle after reset");

endmodule

bind tcdm_burst_engine tcdm_burst_chk i_chk (
  .CLK  (CLK),
  .rst  (rst),
  .req  (tcdm_req),
  .rsp  (tcdm_rsp),
  .busy (busy)
);

`default_nettype wire

// File: dv/tb_fabric_test.sv
// fabric test block testbench
// table-driven register, single access and burst tests against two TCDM models
`timescale 1ns/1ps
`default_nettype none

module tb_fabric_test
  import fabric_bus_pkg::*, fabric_regmap_pkg::*;
;

  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_BURST = 2;
  localparam int OP_WAIT  = 3;
  localparam int OP_MEM   = 4;
  localparam int OP_PIN   = 5;
  localparam int MAX_ENTRIES = 96;
  localparam logic [79:0] IO_IN_VAL = 80'h1234_89abcdef_5a5a6b6b;

  logic CLK;
  logic rst;
  lint_req_t lint_req;
  lint_rsp_t lint_rsp;
  tcdm_req_t tcdm_req [N_PORTS];
  tcdm_rsp_t tcdm_rsp [N_PORTS];
  logic [FPGAIO_W-1:0] fpgaio_in;
  logic [FPGAIO_W-1:0] fpgaio_out;
  logic [FPGAIO_W-1:0] fpgaio_oe;
  logic [EVENTS_W-1:0] events;

  int tab_op [MAX_ENTRIES];
  int tab_port [MAX_ENTRIES];
  logic [31:0] tab_addr [MAX_ENTRIES];
  logic [31:0] tab_data [MAX_ENTRIES];
  logic [31:0] tab_exp [MAX_ENTRIES];
  int n_entries = 0;
  int n_fail = 0;
  int cycles = 0;
  int cycle_limit = 0;

  fabric_test_top i_dut (.*);

  tb_tcdm_mem #(.SEED(32'd40)) i_mem_0 (.CLK, .rst, .req(tcdm_req[0]), .rsp(tcdm_rsp[0]));
  tb_tcdm_mem #(.SEED(32'd41)) i_mem_1 (.CLK, .rst, .req(tcdm_req[1]), .rsp(tcdm_rsp[1]));

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // model fill depends on port and full word index
  function automatic logic [31:0] model_fill(input int p, input int idx);
    return (32'h9e3779b9 * (idx + 1)) ^ (p != 0 ? 32'h5555aaaa : 32'h0);
  endfunction

  function automatic logic [31:0] model_word(input int p, input int idx);
    return (p == 0) ? i_mem_0.mem[idx] : i_mem_1.mem[idx];
  endfunction

  function automatic logic [31:0] pin_word(input int code);
    logic [95:0] v;
    v = (code < 3) ? {16'h0, fpgaio_out} : {16'h0, fpgaio_oe};
    if (code == 6) return 32'(events);
    return v[32*(code % 3) +: 32];
  endfunction

  task automatic add(input int op, input int p, input logic [31:0] a,
                     input logic [31:0] d, input logic [31:0] e);
    tab_op[n_entries] = op;
    tab_port[n_entries] = p;
    tab_addr[n_entries] = a;
    tab_data[n_entries] = d;
    tab_exp[n_entries] = e;
    n_entries++;
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge CLK);
    lint_req <= '{1'b1, 1'b0, a[LINT_AW-1:0], d, 4'hf};
    do @(posedge CLK); while (!lint_rsp.gnt);
    lint_req <= '0;   // drop in the cycle after gnt
    do @(posedge CLK); while (!lint_rsp.valid);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
    @(posedge CLK);
    lint_req <= '{1'b1, 1'b1, a[LINT_AW-1:0], 32'h0, 4'hf};
    do @(posedge CLK); while (!lint_rsp.gnt);
    lint_req <= '0;
    do @(posedge CLK); while (!lint_rsp.valid);
    d = lint_rsp.rdata;
  endtask

  task automatic wait_port_idle(input int p);
    logic [31:0] st;
    do bus_read(32'(BUSY_STATUS), st); while (st[p]);
  endtask

  task automatic build_table();
    add(OP_WR, 0, 32'h00, 32'h80000100, 0);
    add(OP_RD, 0, 32'h00, 0, 32'h80000100);
    add(OP_WR, 0, 32'h70, 32'h4, 0);
    add(OP_RD, 0, 32'h70, 0, 32'h4);
    add(OP_WR, 0, 32'h40, 32'h11223344, 0);
    add(OP_WR, 0, 32'h44, 32'h55667788, 0);
    add(OP_WR, 0, 32'h48, 32'hdeadbeef, 0);
    add(OP_RD, 0, 32'h48, 0, 32'h0000beef);   // only bits 79:64 exist
    add(OP_PIN, 0, 0, 0, 32'h11223344);
    add(OP_PIN, 0, 1, 0, 32'h55667788);
    add(OP_PIN, 0, 2, 0, 32'h0000beef);
    add(OP_WR, 0, 32'h54, 32'hffff0000, 0);
    add(OP_RD, 0, 32'h54, 0, 32'hffff0000);
    add(OP_PIN, 0, 4, 0, 32'hffff0000);
    add(OP_RD, 0, 32'h800, 0, 32'hca11ef3a);
    add(OP_RD, 0, 32'h60, 0, IO_IN_VAL[31:0]);
    add(OP_RD, 0, 32'h64, 0, IO_IN_VAL[63:32]);
    add(OP_RD, 0, 32'h68, 0, 32'(IO_IN_VAL[79:64]));
    add(OP_PIN, 0, 6, 0, 32'(IO_IN_VAL[15:0]));
    // single write on port 0, single read on port 1
    add(OP_WR, 0, 32'h00, 32'h00000040, 0);
    add(OP_WR, 0, 32'h80, 32'hfeedf00d, 0);
    add(OP_WAIT, 0, 0, 1, 0);
    add(OP_MEM, 0, 16, 0, 32'hfeedf00d);
    add(OP_WR, 1, 32'h04, 32'h80000044, 0);
    add(OP_WR, 1, 32'h84, 32'h0, 0);
    add(OP_WAIT, 1, 0, 1, 0);
    add(OP_RD, 1, 32'h84, 0, model_fill(1, 17));
    // read burst of 4 on port 0
    add(OP_WR, 0, 32'h00, 32'h80000100, 0);
    add(OP_BURST, 0, 32'h200, 4, 0);
    for (int k = 0; k < 4; k++) add(OP_RD, 0, 32'h1000 + 4 * k, 0, model_fill(0, 64 + k));
    add(OP_RD, 0, 32'h00, 0, 32'h80000110);
    // write burst of 3 on port 1
    for (int k = 0; k < 3; k++) add(OP_WR, 1, 32'h2000 + 4 * k, 32'h0b0b0000 + k, 0);
    add(OP_WR, 1, 32'h04, 32'h00000300, 0);
    add(OP_WR, 1, 32'h70, 32'h3, 0);
    add(OP_BURST, 1, 32'h204, 3, 0);
    for (int k = 0; k < 3; k++) add(OP_MEM, 1, 192 + k, 0, 32'h0b0b0000 + k);
    // both ports at once, second launch on port 0 lands while busy
    for (int k = 0; k < 5; k++) add(OP_WR, 1, 32'h2000 + 4 * k, 32'h0c0c0000 + k, 0);
    add(OP_WR, 0, 32'h00, 32'h80000180, 0);
    add(OP_WR, 1, 32'h04, 32'h00000380, 0);
    add(OP_WR, 0, 32'h70, 32'h5, 0);
    add(OP_WR, 0, 32'h200, 32'h1, 0);
    add(OP_WR, 1, 32'h204, 32'h1, 0);
    add(OP_WR, 0, 32'h200, 32'h1, 0);
    add(OP_WAIT, 0, 0, 5, 0);
    add(OP_WAIT, 1, 0, 5, 0);
    add(OP_RD, 0, 32'h00, 0, 32'h80000194);
    add(OP_RD, 1, 32'h04, 0, 32'h00000394);
    for (int k = 0; k < 5; k++) add(OP_RD, 0, 32'h1000 + 4 * k, 0, model_fill(0, 96 + k));
    for (int k = 0; k < 5; k++) add(OP_MEM, 1, 224 + k, 0, 32'h0c0c0000 + k);
  endtask

  task automatic run_entry(input int i);
    logic [31:0] got;
    logic        compare;
    got = '0;
    compare = 1'b1;
    case (tab_op[i])
      OP_WR: begin
        bus_write(tab_addr[i], tab_data[i]);
        compare = 1'b0;
      end
      OP_RD: bus_read(tab_addr[i], got);
      OP_BURST: begin
        bus_write(32'(BURST_LEN), tab_data[i]);
        bus_write(tab_addr[i], 32'h1);
        wait_port_idle(tab_port[i]);
        compare = 1'b0;
      end
      OP_WAIT: begin
        wait_port_idle(tab_port[i]);
        compare = 1'b0;
      end
      OP_MEM: got = model_word(tab_port[i], int'(tab_addr[i]));
      default: got = pin_word(int'(tab_addr[i]));
    endcase
    if (!compare) begin
      $display("test %0d op %0d port %0d addr 0x%h done", i, tab_op[i], tab_port[i],
               tab_addr[i]);
    end else begin
      assert (got == tab_exp[i]) begin
        $display("test %0d op %0d port %0d addr 0x%h ok", i, tab_op[i], tab_port[i],
                 tab_addr[i]);
      end else begin
        $display("error at %0t: test %0d addr 0x%h got 0x%h expected 0x%h",
                 $time, i, tab_addr[i], got, tab_exp[i]);
        n_fail++;
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    lint_req = '0;
    fpgaio_in = IO_IN_VAL;
    for (int i = 0; i < 256; i++) begin
      i_mem_0.mem[i] = model_fill(0, i);
      i_mem_1.mem[i] = model_fill(1, i);
    end
    build_table();
    for (int i = 0; i < n_entries; i++) begin
      cycle_limit += 10;
      if (tab_op[i] == OP_BURST || tab_op[i] == OP_WAIT) cycle_limit += 8 * int'(tab_data[i]);
    end
    cycle_limit = 2 * (cycle_limit + 4);
    repeat (4) @(posedge CLK);
    rst <= 1'b0;
    for (int i = 0; i < n_entries; i++) run_entry(i);
    $display("tests %0d passed %0d failed %0d", n_entries, n_entries - n_fail, n_fail);
    if (n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/fabric_bus_pkg.sv
common/fabric_regmap_pkg.sv
hdl/oper_ram.sv
lint_slave/lint_reg_slave.sv
tcdm_dma/tcdm_burst_engine.sv
hdl/fabric_test_top.sv
dv/tb_tcdm_mem.sv
dv/tcdm_burst_chk.sv
dv/tb_fabric_test.sv

// File: Makefile
TOP = tb_fabric_test

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
